// ==== Bender.yml ====
package:
  name: spi_wb8

sources:
  - include_dirs:
      - common
    files:
      - common/spi_pkg.sv
      - common/spi_xfer_if.sv
      - hw/spi_bus_regs.sv
      - spi_engine/spi_clk_gen.sv
      - spi_engine/spi_shifter.sv
      - hw/spi_wb8_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - testbench/tb_spi_wb8.sv

// ==== common/spi_defines.svh ====
`ifndef SPI_DEFINES_SVH
`define SPI_DEFINES_SVH

// width of one SPI transfer word
`define SPI_DATA_W 8

// system clocks per SPI clock half period
`define SPI_CLK_DIV 2

`endif

// ==== common/spi_pkg.sv ====
`default_nettype none

package spi_pkg;

    // wishbone register offsets
    typedef enum logic [1:0] {
        reg_data       = 2'd0,
        reg_cs         = 2'd1,
        reg_status     = 2'd2,
        reg_status_alt = 2'd3
    } spi_reg_e;

    // shift engine sequencing
    typedef enum logic [1:0] {
        idle     = 2'd0,
        shifting = 2'd1,
        done     = 2'd2
    } shift_state_e;

endpackage

`default_nettype wire

// ==== common/spi_xfer_if.sv ====
`default_nettype none
`include "spi_defines.svh"

interface spi_xfer_if;

    // one-cycle request, only while busy is low
    logic                   start;
    logic [`SPI_DATA_W-1:0] tx_data;

    // engine side
    logic                   busy;
    logic [`SPI_DATA_W-1:0] rx_data;

    modport ctrl (
        output start,
        output tx_data,
        input  busy,
        input  rx_data
    );

    modport engine (
        input  start,
        input  tx_data,
        output busy,
        output rx_data
    );

endinterface

`default_nettype wire

// ==== files.f ====
+incdir+common
common/spi_pkg.sv
common/spi_xfer_if.sv
hw/spi_bus_regs.sv
spi_engine/spi_clk_gen.sv
spi_engine/spi_shifter.sv
hw/spi_wb8_top.sv
testbench/tb_spi_wb8.sv

// ==== hw/spi_bus_regs.sv ====
`default_nettype none
`include "spi_defines.svh"

module spi_bus_regs
    import spi_pkg::*;
(
    input  logic                   CLK_I,
    input  logic                   rst,
    input  logic                   stb,
    input  logic                   we,
    input  spi_reg_e               adr,
    input  logic [`SPI_DATA_W-1:0] wdata,
    output logic [`SPI_DATA_W-1:0] rdata,
    output logic                   ack,
    output logic                   cs_n,
    spi_xfer_if.ctrl               xfer
);

    logic                   ack_q;
    logic                   cs_q;
    logic                   start_q;
    logic [`SPI_DATA_W-1:0] tx_q;
    logic                   access;
    logic                   ready;

    // a held strobe is taken once, the ack cycle lets the master drop it
    assign access = stb & ~ack_q;
    assign ready  = ~(xfer.busy | start_q);

    always_ff @(posedge CLK_I) begin
        if (rst) begin
            ack_q   <= 1'b0;
            cs_q    <= 1'b0;
            start_q <= 1'b0;
        end else begin
            ack_q   <= access;
            start_q <= 1'b0;
            if (access && we) begin
                case (adr)
                    // dropped silently while a transfer runs
                    reg_data: begin
                        if (ready) begin
                            start_q <= 1'b1;
                        end
                    end
                    reg_cs: begin
                        cs_q <= wdata[0];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge CLK_I) begin
        if (access && we && adr == reg_data && ready) begin
            tx_q <= wdata;
        end
        if (access && !we) begin
            case (adr)
                reg_data:       rdata <= xfer.rx_data;
                reg_cs:         rdata <= {{(`SPI_DATA_W-1){1'b0}}, cs_q};
                reg_status,
                reg_status_alt: rdata <= {{(`SPI_DATA_W-1){1'b0}}, ready};
            endcase
        end
    end

    assign ack          = ack_q & stb;
    assign cs_n         = ~cs_q;
    assign xfer.start   = start_q;
    assign xfer.tx_data = tx_q;

    // one ack per held strobe
    assert property (@(posedge CLK_I) disable iff (rst)
        (ack && stb) |=> !ack);

    // the engine has to be idle when a start arrives
    assert property (@(posedge CLK_I) disable iff (rst)
        !(xfer.start && xfer.busy));

endmodule

`default_nettype wire

// ==== hw/spi_wb8_top.sv ====
`default_nettype none
`include "spi_defines.svh"

module spi_wb8_top
    import spi_pkg::*;
(
    input  logic                   CLK_I,
    input  logic                   rst,
    input  logic                   STB_I,
    input  logic                   WE_I,
    input  logic [1:0]             ADR_I,
    input  logic [`SPI_DATA_W-1:0] DAT_I,
    output logic [`SPI_DATA_W-1:0] DAT_O,
    output logic                   ACK_O,
    input  logic                   I_spi_miso,
    output logic                   O_spi_clk,
    output logic                   O_spi_mosi,
    output logic                   O_spi_cs
);

    logic clk_en;
    logic clk_rise;
    logic clk_fall;

    spi_xfer_if u_xfer ();

    // bus side
    spi_bus_regs u_regs (
        .CLK_I (CLK_I),
        .rst   (rst),
        .stb   (STB_I),
        .we    (WE_I),
        .adr   (spi_reg_e'(ADR_I)),
        .wdata (DAT_I),
        .rdata (DAT_O),
        .ack   (ACK_O),
        .cs_n  (O_spi_cs),
        .xfer  (u_xfer.ctrl)
    );

    spi_clk_gen u_clk_gen (
        .CLK_I (CLK_I),
        .rst   (rst),
        .en    (clk_en),
        .rise  (clk_rise),
        .fall  (clk_fall)
    );

    // pin side
    spi_shifter u_shifter (
        .CLK_I (CLK_I),
        .rst   (rst),
        .xfer  (u_xfer.engine),
        .rise  (clk_rise),
        .fall  (clk_fall),
        .en    (clk_en),
        .miso  (I_spi_miso),
        .mosi  (O_spi_mosi),
        .sclk  (O_spi_clk)
    );

endmodule

`default_nettype wire

// ==== spi_engine/spi_clk_gen.sv ====
`default_nettype none
`include "spi_defines.svh"

module spi_clk_gen (
    input  logic CLK_I,
    input  logic rst,
    input  logic en,
    output logic rise,
    output logic fall
);

    localparam int CNT_W = $clog2(`SPI_CLK_DIV + 1);

    logic [CNT_W-1:0] cnt;
    logic             phase;
    logic             term;

    // last system clock of a half period
    assign term = (cnt == CNT_W'(`SPI_CLK_DIV - 1));

    always_ff @(posedge CLK_I) begin
        if (rst || !en) begin
            // restart so the first strobe is always a fall
            cnt   <= '0;
            phase <= 1'b0;
            rise  <= 1'b0;
            fall  <= 1'b0;
        end else begin
            rise <= term & phase;
            fall <= term & ~phase;
            if (term) begin
                cnt   <= '0;
                phase <= ~phase;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // every rise trails a fall by one half period
    assert property (@(posedge CLK_I) disable iff (rst)
        rise |-> !fall && $past(fall, `SPI_CLK_DIV));

endmodule

`default_nettype wire

// ==== spi_engine/spi_shifter.sv ====
`default_nettype none
`include "spi_defines.svh"

module spi_shifter
    import spi_pkg::*;
(
    input  logic       CLK_I,
    input  logic       rst,
    spi_xfer_if.engine xfer,
    input  logic       rise,
    input  logic       fall,
    output logic       en,
    input  logic       miso,
    output logic       mosi,
    output logic       sclk
);

    localparam int CNT_W = $clog2(`SPI_DATA_W + 1);

    shift_state_e           state;
    logic [CNT_W-1:0]       bit_cnt;
    logic [`SPI_DATA_W-1:0] shreg;
    logic [`SPI_DATA_W-1:0] rx_q;
    logic                   miso_q;
    logic                   shift_out;

    // the leading fall only gives MOSI its setup half period
    assign shift_out = (state == shifting) && fall && (bit_cnt != '0);

    always_ff @(posedge CLK_I) begin
        if (rst) begin
            state   <= idle;
            bit_cnt <= '0;
            sclk    <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (xfer.start) begin
                        state   <= shifting;
                        bit_cnt <= '0;
                    end
                end
                shifting: begin
                    if (rise) begin
                        sclk    <= 1'b1;
                        bit_cnt <= bit_cnt + 1'b1;
                    end else if (shift_out) begin
                        sclk <= 1'b0;
                        // final fall after the last sample
                        if (bit_cnt == CNT_W'(`SPI_DATA_W)) begin
                            state <= done;
                        end
                    end
                end
                done: begin
                    state <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // msb first, received bits enter at the bottom
    always_ff @(posedge CLK_I) begin
        if (state == idle && xfer.start) begin
            shreg <= xfer.tx_data;
        end else if (shift_out) begin
            shreg <= {shreg[`SPI_DATA_W-2:0], miso_q};
        end
        if (state == shifting && rise) begin
            miso_q <= miso;
        end
    end

    always_ff @(posedge CLK_I) begin
        if (rst) begin
            rx_q <= '0;
        end else if (state == done) begin
            rx_q <= shreg;
        end
    end

    assign en           = (state == shifting);
    assign mosi         = (state == shifting) & shreg[`SPI_DATA_W-1];
    assign xfer.busy    = (state != idle);
    assign xfer.rx_data = rx_q;

    // mode 0 idles with the clock low
    assert property (@(posedge CLK_I) disable iff (rst)
        (state != shifting) |-> !sclk);

endmodule

`default_nettype wire

// ==== testbench/tb_spi_wb8.sv ====
`default_nettype none
`include "spi_defines.svh"

module tb_spi_wb8
    import spi_pkg::*;
();

    localparam int ACK_LIMIT  = 8;
    // each poll takes at least three clocks so this covers a whole transfer
    localparam int POLL_LIMIT = 16 * `SPI_CLK_DIV + 8;
    localparam int RANDOM_OPS = 40;

    logic                   CLK_I;
    logic                   rst;
    logic                   STB_I;
    logic                   WE_I;
    logic [1:0]             ADR_I;
    logic [`SPI_DATA_W-1:0] DAT_I;
    logic [`SPI_DATA_W-1:0] DAT_O;
    logic                   ACK_O;
    logic                   I_spi_miso;
    logic                   O_spi_clk;
    logic                   O_spi_mosi;
    logic                   O_spi_cs;

    logic [31:0]            rng_state;

    // slave model state
    logic                   sclk_prev;
    logic [`SPI_DATA_W-1:0] slave_tx;
    logic [`SPI_DATA_W-1:0] slave_rx;
    int                     slave_bits;

    // register model
    logic                   model_cs;
    logic [`SPI_DATA_W-1:0] model_rx;

    spi_wb8_top u_dut (
        .CLK_I      (CLK_I),
        .rst        (rst),
        .STB_I      (STB_I),
        .WE_I       (WE_I),
        .ADR_I      (ADR_I),
        .DAT_I      (DAT_I),
        .DAT_O      (DAT_O),
        .ACK_O      (ACK_O),
        .I_spi_miso (I_spi_miso),
        .O_spi_clk  (O_spi_clk),
        .O_spi_mosi (O_spi_mosi),
        .O_spi_cs   (O_spi_cs)
    );

    initial begin
        CLK_I = 1'b0;
        forever #10 CLK_I = ~CLK_I;
    end

    // mode 0 slave samples on rising SCLK and moves to the next bit on falling SCLK
    always @(negedge CLK_I) begin
        if (O_spi_clk && !sclk_prev) begin
            slave_rx   = {slave_rx[`SPI_DATA_W-2:0], O_spi_mosi};
            slave_bits = slave_bits + 1;
        end else if (!O_spi_clk && sclk_prev) begin
            slave_tx   = {slave_tx[`SPI_DATA_W-2:0], 1'b0};
            I_spi_miso = slave_tx[`SPI_DATA_W-1];
        end
        sclk_prev = O_spi_clk;
    end

    function automatic logic [7:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[31:24];
    endfunction

    task automatic fail_now(input string why);
        $display("TB FAILED");
        $display("%s", why);
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else fail_now($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    // strobe stays high a cycle past the ack to catch a repeated ack
    task automatic bus_access(input logic wr, input spi_reg_e adr,
                              input logic [`SPI_DATA_W-1:0] wdat,
                              output logic [`SPI_DATA_W-1:0] rdat);
        int waited;
        @(negedge CLK_I);
        STB_I  = 1'b1;
        WE_I   = wr;
        ADR_I  = adr;
        DAT_I  = wdat;
        waited = 0;
        do begin
            @(negedge CLK_I);
            waited++;
        end while (!ACK_O && waited < ACK_LIMIT);
        assert (ACK_O) else fail_now("no ack from the bus register stage");
        check_value("ack_latency", waited, 1);
        rdat = DAT_O;
        @(negedge CLK_I);
        assert (!ACK_O) else fail_now("ack stayed high for a second cycle");
        STB_I = 1'b0;
        WE_I  = 1'b0;
    endtask

    task automatic bus_write(input spi_reg_e adr, input logic [`SPI_DATA_W-1:0] wdat);
        logic [`SPI_DATA_W-1:0] unused;
        bus_access(1'b1, adr, wdat, unused);
    endtask

    task automatic bus_read(input spi_reg_e adr, output logic [`SPI_DATA_W-1:0] rdat);
        bus_access(1'b0, adr, '0, rdat);
    endtask

    task automatic read_status(input spi_reg_e adr, output logic ready);
        logic [`SPI_DATA_W-1:0] rdat;
        bus_read(adr, rdat);
        ready = rdat[0];
        if (ready) begin
            check_value("O_spi_clk", O_spi_clk, 1'b0);
        end
    endtask

    task automatic wait_ready();
        logic ready;
        int   polls;
        ready = 1'b0;
        polls = 0;
        while (!ready && polls < POLL_LIMIT) begin
            read_status(reg_status, ready);
            polls++;
        end
        assert (ready) else fail_now("transfer did not finish within the poll limit");
    endtask

    task automatic write_cs(input logic value);
        logic [`SPI_DATA_W-1:0] rdat;
        bus_write(reg_cs, {{(`SPI_DATA_W-1){1'b0}}, value});
        model_cs = value;
        bus_read(reg_cs, rdat);
        check_value("DAT_O[0]", rdat[0], model_cs);
        check_value("O_spi_cs", O_spi_cs, !model_cs);
    endtask

    // slave answers with reply while an optional second write lands mid transfer
    task automatic run_transfer(input logic [`SPI_DATA_W-1:0] tx,
                                input logic [`SPI_DATA_W-1:0] reply,
                                input logic extra, input logic [`SPI_DATA_W-1:0] extra_tx);
        logic                   ready;
        logic [`SPI_DATA_W-1:0] rdat;
        slave_tx   = reply;
        slave_bits = 0;
        I_spi_miso = reply[`SPI_DATA_W-1];
        bus_write(reg_data, tx);
        read_status(reg_status, ready);
        check_value("status_ready", ready, 1'b0);
        if (extra) begin
            bus_write(reg_data, extra_tx);
        end
        wait_ready();
        check_value("slave_bits", slave_bits, `SPI_DATA_W);
        check_value("slave_rx", slave_rx, tx);
        if (extra) begin
            // the dropped byte must not start a second transfer
            read_status(reg_status, ready);
            check_value("status_ready", ready, 1'b1);
            check_value("slave_bits", slave_bits, `SPI_DATA_W);
        end
        bus_read(reg_data, rdat);
        check_value("DAT_O", rdat, reply);
        model_rx = reply;
    endtask

    initial begin
        logic [`SPI_DATA_W-1:0] rdat;
        logic [`SPI_DATA_W-1:0] val;
        logic [`SPI_DATA_W-1:0] reply;
        logic                   ready;
        int                     op;
        rst        = 1'b1;
        STB_I      = 1'b0;
        WE_I       = 1'b0;
        ADR_I      = 2'd0;
        DAT_I      = '0;
        I_spi_miso = 1'b0;
        rng_state  = 32'd15841;
        sclk_prev  = 1'b0;
        slave_tx   = '0;
        slave_rx   = '0;
        slave_bits = 0;
        model_cs   = 1'b0;
        model_rx   = '0;
        repeat (3) @(posedge CLK_I);
        @(negedge CLK_I);
        rst = 1'b0;

        check_value("O_spi_cs", O_spi_cs, 1'b1);
        check_value("O_spi_clk", O_spi_clk, 1'b0);
        check_value("O_spi_mosi", O_spi_mosi, 1'b0);
        check_value("ACK_O", ACK_O, 1'b0);
        read_status(reg_status, ready);
        check_value("status_ready", ready, 1'b1);

        repeat (4) begin
            val = next_random();
            write_cs(val[0]);
        end

        val   = next_random();
        reply = next_random();
        run_transfer(val, reply, 1'b0, '0);

        // second write while busy is acked and dropped
        val   = next_random();
        reply = next_random();
        rdat  = next_random();
        run_transfer(val, reply, 1'b1, rdat);
        val   = next_random();
        reply = next_random();
        run_transfer(val, reply, 1'b0, '0);

        for (int i = 0; i < RANDOM_OPS; i++) begin
            op  = next_random() % 5;
            val = next_random();
            case (op)
                0: begin
                    reply = next_random();
                    run_transfer(val, reply, 1'b0, '0);
                end
                1: write_cs(val[0]);
                2: begin
                    bus_read(reg_cs, rdat);
                    check_value("DAT_O[0]", rdat[0], model_cs);
                end
                3: begin
                    read_status(spi_reg_e'(val[0] ? reg_status_alt : reg_status), ready);
                    check_value("status_ready", ready, 1'b1);
                end
                default: begin
                    bus_read(reg_data, rdat);
                    check_value("DAT_O", rdat, model_rx);
                end
            endcase
            check_value("O_spi_cs", O_spi_cs, !model_cs);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire
